/* flist.f */
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/hazard_unit.sv
rtl/pipeline_cpu.sv
sim/tb_memories.sv
sim/tb_pipeline_cpu.sv

/* rtl/alu.sv */
/*
 * alu: add, sub, and, or, sll, sra with not-equal and signed
 * less-than flags from a - b
 */
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   operand_a,
    input  cpu_pkg::word_t   operand_b,
    input  cpu_pkg::alu_op_e op,
    input  logic [4:0]       shamt,
    output cpu_pkg::word_t   result,
    output logic             not_equal,
    output logic             less_than
);
    import cpu_pkg::*;

    word_t diff;
    logic  sub_ovf;

    assign diff = operand_a - operand_b;
    // signed overflow of a - b
    assign sub_ovf = (operand_a[XLEN-1] != operand_b[XLEN-1]) &&
                     (diff[XLEN-1] != operand_a[XLEN-1]);

    assign not_equal = |diff;
    // sign of the true difference
    assign less_than = diff[XLEN-1] ^ sub_ovf;

    always_comb begin
        case (op)
            ALU_ADD: result = operand_a + operand_b;
            ALU_SUB: result = diff;
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            ALU_SLL: result = operand_a << shamt;
            ALU_SRA: result = word_t'($signed(operand_a) >>> shamt);
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/cpu_pkg.sv */
/*
 * cpu_pkg: shared widths, instruction fields, opcode enums and
 * pipeline register structs for the five-stage core
 */
`default_nettype none

package cpu_pkg;

    // data, address and instruction width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // link register for jal
    localparam reg_addr_t REG_RA = 5'd31;
    // all-zero word decodes as add r0, r0, r0
    localparam word_t NOP_INSTR = '0;

    // instruction field positions
    localparam int OPC_MSB   = 31;
    localparam int OPC_LSB   = 27;
    localparam int RD_MSB    = 26;
    localparam int RD_LSB    = 22;
    localparam int RS_MSB    = 21;
    localparam int RS_LSB    = 17;
    localparam int RT_MSB    = 16;
    localparam int RT_LSB    = 12;
    localparam int SHAMT_MSB = 11;
    localparam int SHAMT_LSB = 7;
    localparam int ALUOP_MSB = 6;
    localparam int ALUOP_LSB = 2;
    // 17-bit immediate, sign-extended
    localparam int IMM_MSB   = 16;
    localparam int IMM_LSB   = 0;
    // 27-bit jump target
    localparam int TGT_MSB   = 26;
    localparam int TGT_LSB   = 0;

    typedef enum logic [4:0] {
        OPC_ALU  = 5'd0,
        OPC_J    = 5'd1,
        OPC_BNE  = 5'd2,
        OPC_JAL  = 5'd3,
        OPC_JR   = 5'd4,
        OPC_ADDI = 5'd5,
        OPC_BLT  = 5'd6,
        OPC_SW   = 5'd7,
        OPC_LW   = 5'd8
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    // pipeline registers
    typedef struct packed {
        word_t pc_plus1;
        word_t ir;
    } fd_t;

    typedef struct packed {
        word_t pc_plus1;
        word_t ir;
        word_t a;
        word_t b;
    } dx_t;

    typedef struct packed {
        word_t ir;
        word_t o;
        word_t b;
    } xm_t;

    typedef struct packed {
        word_t ir;
        word_t o;
        word_t d;
    } mw_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic xm_a;
        logic mw_a;
        logic xm_b;
        logic mw_b;
        logic mw_dm;
    } bypass_t;

    // opcodes that write rd in write-back
    function automatic logic writes_reg(input opcode_e op);
        return op inside {OPC_ALU, OPC_ADDI, OPC_LW, OPC_JAL};
    endfunction

    // opcodes with rs as a source
    function automatic logic reads_rs(input opcode_e op);
        return op inside {OPC_ALU, OPC_BNE, OPC_ADDI, OPC_BLT, OPC_SW, OPC_LW};
    endfunction

    // opcodes with rd as a source, read on port b
    function automatic logic reads_rd(input opcode_e op);
        return op inside {OPC_SW, OPC_BNE, OPC_JR, OPC_BLT};
    endfunction

endpackage

`default_nettype wire

/* rtl/decode_stage.sv */
/*
 * decode_stage: register-file read addresses and the D/X register,
 * with a bubble on load-use stall or taken redirect
 */
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
    input  wire                 clock,
    input  wire                 arst_n,
    input  cpu_pkg::fd_t        fd,
    input  wire                 stall,
    input  cpu_pkg::redirect_t  redirect,
    input  cpu_pkg::word_t      data_read_reg_a,
    input  cpu_pkg::word_t      data_read_reg_b,
    output cpu_pkg::reg_addr_t  ctrl_read_reg_a,
    output cpu_pkg::reg_addr_t  ctrl_read_reg_b,
    output cpu_pkg::dx_t        dx
);
    import cpu_pkg::*;

    opcode_e d_opc;
    logic    bubble;

    assign d_opc = opcode_e'(fd.ir[OPC_MSB:OPC_LSB]);

    // port a is always rs
    assign ctrl_read_reg_a = fd.ir[RS_MSB:RS_LSB];
    // port b: rd for sw/bne/jr/blt, rt for everything else
    assign ctrl_read_reg_b = reads_rd(d_opc) ? fd.ir[RD_MSB:RD_LSB]
                                             : fd.ir[RT_MSB:RT_LSB];

    // held instruction in D must not also go to X
    // branch in X flushes the instruction in D
    assign bubble = stall || redirect.taken;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dx <= '0;
        end else begin
            dx.pc_plus1 <= fd.pc_plus1;
            dx.ir       <= bubble ? NOP_INSTR : fd.ir;
            // operands pass through even for a bubble, nop ignores them
            dx.a        <= data_read_reg_a;
            dx.b        <= data_read_reg_b;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
/*
 * execute_stage: operand bypass, ALU control, branch and jump
 * resolution, and the X/M register
 */
`default_nettype none
`timescale 1ns/1ps

module execute_stage (
    input  wire                 clock,
    input  wire                 arst_n,
    input  cpu_pkg::dx_t        dx,
    input  cpu_pkg::bypass_t    bypass,
    input  cpu_pkg::word_t      xm_o,
    input  cpu_pkg::word_t      wb_data,
    output cpu_pkg::redirect_t  redirect,
    output cpu_pkg::xm_t        xm
);
    import cpu_pkg::*;

    opcode_e   x_opc;
    alu_op_e   alu_fn;
    word_t     opnd_a;
    word_t     opnd_b;
    word_t     alu_b;
    word_t     imm;
    word_t     jump_target;
    word_t     branch_target;
    word_t     alu_result;
    logic      alu_neq;
    logic      alu_lt;
    logic      use_imm;
    reg_addr_t dest;

    assign x_opc = opcode_e'(dx.ir[OPC_MSB:OPC_LSB]);

    assign imm = {{(XLEN-IMM_MSB-1){dx.ir[IMM_MSB]}}, dx.ir[IMM_MSB:IMM_LSB]};
    assign jump_target = {{(XLEN-TGT_MSB-1){1'b0}}, dx.ir[TGT_MSB:TGT_LSB]};
    assign branch_target = dx.pc_plus1 + imm;

    // bypass: X/M first, it is the younger result
    assign opnd_a = bypass.xm_a ? xm_o :
                    bypass.mw_a ? wb_data : dx.a;
    assign opnd_b = bypass.xm_b ? xm_o :
                    bypass.mw_b ? wb_data : dx.b;

    // addi, lw, sw add the immediate
    assign use_imm = x_opc inside {OPC_ADDI, OPC_LW, OPC_SW};
    assign alu_b   = use_imm ? imm : opnd_b;

    always_comb begin
        case (x_opc)
            OPC_ALU:          alu_fn = alu_op_e'(dx.ir[ALUOP_MSB:ALUOP_LSB]);
            OPC_BNE, OPC_BLT: alu_fn = ALU_SUB;
            default:          alu_fn = ALU_ADD;
        endcase
    end

    alu u_alu (
        .operand_a (opnd_a),
        .operand_b (alu_b),
        .op        (alu_fn),
        .shamt     (dx.ir[SHAMT_MSB:SHAMT_LSB]),
        .result    (alu_result),
        .not_equal (alu_neq),
        .less_than (alu_lt)
    );

    // branch resolution, ALU computes rs - rd
    always_comb begin
        redirect.taken  = 1'b0;
        redirect.target = branch_target;
        case (x_opc)
            OPC_J, OPC_JAL: begin
                redirect.taken  = 1'b1;
                redirect.target = jump_target;
            end
            OPC_JR: begin
                // rd arrives on port b
                redirect.taken  = 1'b1;
                redirect.target = opnd_b;
            end
            // rd != rs
            OPC_BNE: redirect.taken = alu_neq;
            // rd < rs, so rs is neither equal nor less
            OPC_BLT: redirect.taken = alu_neq && !alu_lt;
            default: redirect.taken = 1'b0;
        endcase
    end

    // jal links into r31
    assign dest = (x_opc == OPC_JAL) ? REG_RA : dx.ir[RD_MSB:RD_LSB];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            xm <= '0;
        end else begin
            xm.ir <= {dx.ir[OPC_MSB:OPC_LSB], dest, dx.ir[RS_MSB:0]};
            xm.o  <= (x_opc == OPC_JAL) ? dx.pc_plus1 : alu_result;
            // store data, still patched in M if W writes it
            xm.b  <= opnd_b;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
/*
 * fetch_stage: PC register, next-PC select and the F/D register
 */
`default_nettype none
`timescale 1ns/1ps

module fetch_stage (
    input  wire                 clock,
    input  wire                 arst_n,
    input  wire                 stall,
    input  cpu_pkg::redirect_t  redirect,
    input  cpu_pkg::word_t      q_imem,
    output cpu_pkg::word_t      address_imem,
    output cpu_pkg::fd_t        fd
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc_plus1;

    // word addressed, one step per instruction
    assign pc_plus1     = pc + word_t'(1);
    assign address_imem = pc;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            fd <= '0;
        end else if (redirect.taken) begin
            // redirect beats stall
            // the word fetched this cycle is dropped
            pc <= redirect.target;
            fd <= '{pc_plus1: pc_plus1, ir: NOP_INSTR};
        end else if (!stall) begin
            pc <= pc_plus1;
            fd <= '{pc_plus1: pc_plus1, ir: q_imem};
        end
        // stall: pc and F/D hold
    end

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
/*
 * hazard_unit: bypass selects for X and M, and the load-use stall
 */
`default_nettype none
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::fd_t        fd,
    input  cpu_pkg::dx_t        dx,
    input  cpu_pkg::xm_t        xm,
    input  wire                 ctrl_write_enable,
    input  cpu_pkg::reg_addr_t  ctrl_write_reg,
    output cpu_pkg::bypass_t    bypass,
    output logic                stall
);
    import cpu_pkg::*;

    opcode_e   d_opc;
    opcode_e   x_opc;
    opcode_e   m_opc;
    reg_addr_t x_rs;
    reg_addr_t x_rd;
    reg_addr_t x_src_b;
    reg_addr_t m_rd;
    logic      x_reads_a;
    logic      x_reads_b;
    logic      m_writes;
    logic      w_writes;
    logic      d_uses_load;

    assign d_opc = opcode_e'(fd.ir[OPC_MSB:OPC_LSB]);
    assign x_opc = opcode_e'(dx.ir[OPC_MSB:OPC_LSB]);
    assign m_opc = opcode_e'(xm.ir[OPC_MSB:OPC_LSB]);

    // sources of the instruction in X
    assign x_rs      = dx.ir[RS_MSB:RS_LSB];
    assign x_rd      = dx.ir[RD_MSB:RD_LSB];
    assign x_reads_a = reads_rs(x_opc);
    // port b holds rt for alu_op, rd for sw/bne/jr/blt
    assign x_src_b   = (x_opc == OPC_ALU) ? dx.ir[RT_MSB:RT_LSB] : x_rd;
    assign x_reads_b = (x_opc == OPC_ALU) || reads_rd(x_opc);

    // producers in M and W, r0 never forwards
    assign m_rd     = xm.ir[RD_MSB:RD_LSB];
    assign m_writes = writes_reg(m_opc) && (m_rd != '0);
    assign w_writes = ctrl_write_enable && (ctrl_write_reg != '0);

    // M wins over W when both match
    assign bypass.xm_a = x_reads_a && m_writes && (m_rd == x_rs);
    assign bypass.mw_a = x_reads_a && w_writes && (ctrl_write_reg == x_rs);
    assign bypass.xm_b = x_reads_b && m_writes && (m_rd == x_src_b);
    assign bypass.mw_b = x_reads_b && w_writes && (ctrl_write_reg == x_src_b);

    // sw in M takes store data from W
    assign bypass.mw_dm = (m_opc == OPC_SW) && w_writes && (ctrl_write_reg == m_rd);

    // load result not ready until W, the reader in D waits one cycle
    // sw data read of rd left out, mw_dm covers it
    always_comb begin
        d_uses_load = 1'b0;
        if (reads_rs(d_opc) && (fd.ir[RS_MSB:RS_LSB] == x_rd))
            d_uses_load = 1'b1;
        if ((d_opc == OPC_ALU) && (fd.ir[RT_MSB:RT_LSB] == x_rd))
            d_uses_load = 1'b1;
        if (reads_rd(d_opc) && (d_opc != OPC_SW) && (fd.ir[RD_MSB:RD_LSB] == x_rd))
            d_uses_load = 1'b1;
    end

    assign stall = (x_opc == OPC_LW) && (x_rd != '0) && d_uses_load;

endmodule

`default_nettype wire

/* rtl/mem_wb_stage.sv */
/*
 * mem_wb_stage: data memory drive with store-data bypass, the M/W
 * register and write-back select
 */
`default_nettype none
`timescale 1ns/1ps

module mem_wb_stage (
    input  wire                 clock,
    input  wire                 arst_n,
    input  cpu_pkg::xm_t        xm,
    input  cpu_pkg::bypass_t    bypass,
    input  cpu_pkg::word_t      q_dmem,
    output cpu_pkg::word_t      address_dmem,
    output cpu_pkg::word_t      data,
    output logic                wren,
    output logic                ctrl_write_enable,
    output cpu_pkg::reg_addr_t  ctrl_write_reg,
    output cpu_pkg::word_t      data_write_reg
);
    import cpu_pkg::*;

    opcode_e m_opc;
    opcode_e w_opc;
    mw_t     mw;

    assign m_opc = opcode_e'(xm.ir[OPC_MSB:OPC_LSB]);
    assign w_opc = opcode_e'(mw.ir[OPC_MSB:OPC_LSB]);

    // memory stage
    assign address_dmem = xm.o;
    assign wren         = (m_opc == OPC_SW);
    // lw directly ahead of sw lands here from W
    assign data         = bypass.mw_dm ? data_write_reg : xm.b;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mw <= '0;
        end else begin
            mw.ir <= xm.ir;
            mw.o  <= xm.o;
            mw.d  <= q_dmem;
        end
    end

    // write-back stage
    assign ctrl_write_reg    = mw.ir[RD_MSB:RD_LSB];
    // r0 never written, so a nop keeps the enable low
    assign ctrl_write_enable = writes_reg(w_opc) && (ctrl_write_reg != '0);
    // loaded word for lw, ALU or link value otherwise
    assign data_write_reg    = (w_opc == OPC_LW) ? mw.d : mw.o;

endmodule

`default_nettype wire

/* rtl/pipeline_cpu.sv */
/*
 * pipeline_cpu: five-stage core, memories and register file
 * are external and reached through the ports below
 */
`default_nettype none
`timescale 1ns/1ps

module pipeline_cpu (
    input  wire                 clock,
    input  wire                 arst_n,
    // instruction memory
    output cpu_pkg::word_t      address_imem,
    input  cpu_pkg::word_t      q_imem,
    // data memory
    output cpu_pkg::word_t      address_dmem,
    output cpu_pkg::word_t      data,
    output logic                wren,
    input  cpu_pkg::word_t      q_dmem,
    // register file
    output logic                ctrl_write_enable,
    output cpu_pkg::reg_addr_t  ctrl_write_reg,
    output cpu_pkg::reg_addr_t  ctrl_read_reg_a,
    output cpu_pkg::reg_addr_t  ctrl_read_reg_b,
    output cpu_pkg::word_t      data_write_reg,
    input  cpu_pkg::word_t      data_read_reg_a,
    input  cpu_pkg::word_t      data_read_reg_b
);
    import cpu_pkg::*;

    // stage registers, forward
    fd_t       fd;
    dx_t       dx;
    xm_t       xm;
    // control levels, backward
    redirect_t redirect;
    bypass_t   bypass;
    logic      stall;

    fetch_stage u_fetch_stage (
        .clock        (clock),
        .arst_n       (arst_n),
        .stall        (stall),
        .redirect     (redirect),
        .q_imem       (q_imem),
        .address_imem (address_imem),
        .fd           (fd)
    );

    decode_stage u_decode_stage (
        .clock           (clock),
        .arst_n          (arst_n),
        .fd              (fd),
        .stall           (stall),
        .redirect        (redirect),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .dx              (dx)
    );

    // W value doubles as the M/W bypass source
    execute_stage u_execute_stage (
        .clock    (clock),
        .arst_n   (arst_n),
        .dx       (dx),
        .bypass   (bypass),
        .xm_o     (xm.o),
        .wb_data  (data_write_reg),
        .redirect (redirect),
        .xm       (xm)
    );

    mem_wb_stage u_mem_wb_stage (
        .clock             (clock),
        .arst_n            (arst_n),
        .xm                (xm),
        .bypass            (bypass),
        .q_dmem            (q_dmem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .data_write_reg    (data_write_reg)
    );

    hazard_unit u_hazard_unit (
        .fd                (fd),
        .dx                (dx),
        .xm                (xm),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .bypass            (bypass),
        .stall             (stall)
    );

endmodule

`default_nettype wire

/* sim/tb_memories.sv */
/*
 * tb_memories: instruction ROM, data RAM and write-through register
 * file that sit outside the core
 */
`default_nettype none
`timescale 1ns/1ps

module tb_memories (
    input  wire                 clock,
    input  wire                 arst_n,
    input  cpu_pkg::word_t      address_imem,
    output cpu_pkg::word_t      q_imem,
    input  cpu_pkg::word_t      address_dmem,
    input  cpu_pkg::word_t      data,
    input  wire                 wren,
    output cpu_pkg::word_t      q_dmem,
    input  wire                 ctrl_write_enable,
    input  cpu_pkg::reg_addr_t  ctrl_write_reg,
    input  cpu_pkg::reg_addr_t  ctrl_read_reg_a,
    input  cpu_pkg::reg_addr_t  ctrl_read_reg_b,
    input  cpu_pkg::word_t      data_write_reg,
    output cpu_pkg::word_t      data_read_reg_a,
    output cpu_pkg::word_t      data_read_reg_b
);
    import cpu_pkg::*;

    // 256 words each, contents loaded by the testbench top
    word_t rom [0:255];
    word_t ram [0:255];
    word_t rf  [0:31];

    // combinational reads, low 8 address bits
    assign q_imem = rom[address_imem[7:0]];
    assign q_dmem = ram[address_dmem[7:0]];

    always @(posedge clock) begin
        if (wren)
            ram[address_dmem[7:0]] <= data;
    end

    // r0 reads zero
    // a write in the same cycle passes through to the read
    assign data_read_reg_a = (ctrl_read_reg_a == '0) ? '0 :
        (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a) ? data_write_reg :
        rf[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_read_reg_b == '0) ? '0 :
        (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b) ? data_write_reg :
        rf[ctrl_read_reg_b];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                rf[i] <= '0;
        end else if (ctrl_write_enable && ctrl_write_reg != '0) begin
            rf[ctrl_write_reg] <= data_write_reg;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_pipeline_cpu.sv */
/*
 * tb_pipeline_cpu: runs a fixed program on the core and checks every
 * register write and store against an instruction-level model
 */
`default_nettype none
`timescale 1ns/1ps

module tb_pipeline_cpu;
    import cpu_pkg::*;

    logic      clock;
    logic      arst_n;
    word_t     address_imem, q_imem;
    word_t     address_dmem, data, q_dmem;
    logic      wren;
    logic      ctrl_write_enable;
    reg_addr_t ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;
    word_t     data_write_reg, data_read_reg_a, data_read_reg_b;

    // expected events, program order, one queue pair per kind
    reg_addr_t exp_reg_q [$];
    word_t     exp_val_q [$];
    word_t     st_addr_q [$];
    word_t     st_data_q [$];
    word_t     prog [0:255];
    word_t     lfsr_state;
    word_t     head_val, head_addr, head_data;
    reg_addr_t head_reg;
    int        errors, writes_seen, stores_seen;
    int        writes_expected, stores_expected, model_steps;
    logic      model_ready;

    pipeline_cpu u_pipeline_cpu (.*);
    tb_memories  u_memories (.*);

    always #4 clock = ~clock;

    // taps 32, 22, 2, 1
    function automatic word_t lfsr_next(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int nbits, output word_t value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    // multiply spreads every address bit over the word
    function automatic word_t fill_word(input int addr);
        return word_t'(addr + 1) * 32'h9e37_79b9;
    endfunction

    function automatic word_t alu_instr(input alu_op_e fn, input reg_addr_t rd,
                                        input reg_addr_t rs, input reg_addr_t rt,
                                        input logic [4:0] shamt);
        return {OPC_ALU, rd, rs, rt, shamt, fn, 2'b00};
    endfunction

    // rd is the data or compare register for sw, bne, blt, jr
    function automatic word_t imm_instr(input opcode_e opc, input reg_addr_t rd,
                                        input reg_addr_t rs, input logic [16:0] imm);
        return {opc, rd, rs, imm};
    endfunction

    function automatic word_t jump_instr(input opcode_e opc, input logic [26:0] target);
        return {opc, target};
    endfunction

    task automatic report_mismatch(input string name, input word_t got, input word_t expected);
        errors++;
        $display("FAIL time %0t: %s got %h expected %h", $time, name, got, expected);
    endtask

    task automatic build_program();
        word_t r1;
        word_t r2;
        draw_bits(17, r1);
        draw_bits(17, r2);
        for (int i = 0; i < 256; i++)
            prog[i] = NOP_INSTR;
        // back-to-back dependent chain, random addi immediates
        prog[0]  = imm_instr(OPC_ADDI, 5'd1, 5'd0, r1[16:0]);
        prog[1]  = imm_instr(OPC_ADDI, 5'd2, 5'd1, r2[16:0]);
        prog[2]  = alu_instr(ALU_ADD, 5'd3, 5'd1, 5'd2, 5'd0);
        prog[3]  = alu_instr(ALU_SUB, 5'd4, 5'd1, 5'd3, 5'd0);
        prog[4]  = alu_instr(ALU_AND, 5'd5, 5'd4, 5'd3, 5'd0);
        prog[5]  = alu_instr(ALU_OR, 5'd6, 5'd5, 5'd2, 5'd0);
        prog[6]  = alu_instr(ALU_SLL, 5'd7, 5'd6, 5'd0, 5'd3);
        prog[7]  = alu_instr(ALU_SRA, 5'd8, 5'd4, 5'd0, 5'd5);
        // store then load-use
        prog[8]  = imm_instr(OPC_SW, 5'd8, 5'd0, 17'd4);
        prog[9]  = imm_instr(OPC_LW, 5'd9, 5'd0, 17'd4);
        prog[10] = alu_instr(ALU_ADD, 5'd10, 5'd9, 5'd1, 5'd0);
        // lw right before sw of the same register
        prog[11] = imm_instr(OPC_LW, 5'd11, 5'd0, 17'd5);
        prog[12] = imm_instr(OPC_SW, 5'd11, 5'd0, 17'd6);
        prog[13] = imm_instr(OPC_LW, 5'd12, 5'd0, 17'd6);
        prog[14] = imm_instr(OPC_ADDI, 5'd13, 5'd12, 17'd1);
        // branches, r14 = 5 and r15 = -3
        prog[15] = imm_instr(OPC_ADDI, 5'd14, 5'd0, 17'd5);
        prog[16] = imm_instr(OPC_ADDI, 5'd15, 5'd0, 17'(-3));
        prog[17] = imm_instr(OPC_BNE, 5'd14, 5'd14, 17'd9);
        prog[18] = imm_instr(OPC_BNE, 5'd14, 5'd15, 17'd2);
        prog[19] = imm_instr(OPC_ADDI, 5'd16, 5'd0, 17'd111);
        prog[20] = imm_instr(OPC_ADDI, 5'd17, 5'd0, 17'd222);
        prog[21] = imm_instr(OPC_BLT, 5'd14, 5'd15, 17'd5);
        prog[22] = imm_instr(OPC_BLT, 5'd15, 5'd14, 17'd2);
        prog[23] = imm_instr(OPC_ADDI, 5'd16, 5'd0, 17'd333);
        prog[24] = imm_instr(OPC_ADDI, 5'd17, 5'd0, 17'd444);
        // call and return
        prog[25] = jump_instr(OPC_JAL, 27'd30);
        prog[26] = imm_instr(OPC_ADDI, 5'd18, 5'd31, 17'd7);
        prog[27] = imm_instr(OPC_SW, 5'd18, 5'd0, 17'd7);
        // halt loop
        prog[28] = jump_instr(OPC_J, 27'd28);
        prog[29] = imm_instr(OPC_ADDI, 5'd19, 5'd0, 17'd1);
        prog[30] = imm_instr(OPC_ADDI, 5'd20, 5'd0, 17'd9);
        prog[31] = alu_instr(ALU_SLL, 5'd21, 5'd20, 5'd0, 5'd2);
        prog[32] = imm_instr(OPC_JR, 5'd31, 5'd0, 17'd0);
        for (int i = 0; i < 256; i++) begin
            u_memories.rom[i] = prog[i];
            u_memories.ram[i] = fill_word(i);
        end
    endtask

    // one instruction per step, stops at a jump to itself
    task automatic run_model();
        word_t     rf [0:31];
        word_t     ram [0:255];
        word_t     pc, ir, a, b, imm, val, addr;
        reg_addr_t dest;
        opcode_e   opc;
        logic      wr;
        logic      halted;
        for (int i = 0; i < 256; i++)
            ram[i] = fill_word(i);
        for (int i = 0; i < 32; i++)
            rf[i] = '0;
        pc = '0;
        halted = 1'b0;
        model_steps = 0;
        while (!halted && model_steps < 200) begin
            ir   = prog[pc[7:0]];
            opc  = opcode_e'(ir[31:27]);
            a    = rf[ir[21:17]];
            b    = rf[ir[26:22]];
            imm  = {{15{ir[16]}}, ir[16:0]};
            dest = ir[26:22];
            wr   = 1'b0;
            val  = '0;
            model_steps++;
            halted = (opc == OPC_J) && (ir[26:0] == pc[26:0]);
            // pc becomes pc_plus1 before branch offsets apply
            pc = pc + 1;
            case (opc)
                OPC_ALU: begin
                    wr = 1'b1;
                    case (alu_op_e'(ir[6:2]))
                        ALU_ADD: val = a + rf[ir[16:12]];
                        ALU_SUB: val = a - rf[ir[16:12]];
                        ALU_AND: val = a & rf[ir[16:12]];
                        ALU_OR:  val = a | rf[ir[16:12]];
                        ALU_SLL: val = a << ir[11:7];
                        ALU_SRA: val = word_t'($signed(a) >>> ir[11:7]);
                        default: val = '0;
                    endcase
                end
                OPC_ADDI: begin
                    wr  = 1'b1;
                    val = a + imm;
                end
                OPC_LW: begin
                    wr   = 1'b1;
                    addr = a + imm;
                    val  = ram[addr[7:0]];
                end
                OPC_SW: begin
                    addr = a + imm;
                    ram[addr[7:0]] = b;
                    st_addr_q.push_back(addr);
                    st_data_q.push_back(b);
                end
                OPC_BNE: if (b != a) pc = pc + imm;
                OPC_BLT: if ($signed(b) < $signed(a)) pc = pc + imm;
                OPC_J:   pc = {5'b0, ir[26:0]};
                OPC_JAL: begin
                    wr   = 1'b1;
                    dest = 5'd31;
                    val  = pc;
                    pc   = {5'b0, ir[26:0]};
                end
                OPC_JR:  pc = b;
                default: ;
            endcase
            if (wr && dest != '0) begin
                rf[dest] = val;
                exp_reg_q.push_back(dest);
                exp_val_q.push_back(val);
            end
        end
        writes_expected = exp_reg_q.size();
        stores_expected = st_addr_q.size();
    endtask

    // outputs settle well before the falling edge
    always @(negedge clock) begin
        if (arst_n) begin
            // the nop writes r0 and changes nothing
            if (ctrl_write_enable && ctrl_write_reg != '0) begin
                writes_seen++;
                assert (exp_reg_q.size() != 0) else begin
                    errors++;
                    $display("time %0t: unexpected write to r%0d", $time, ctrl_write_reg);
                end
                if (exp_reg_q.size() != 0) begin
                    head_reg = exp_reg_q.pop_front();
                    head_val = exp_val_q.pop_front();
                    assert (ctrl_write_reg == head_reg)
                        else report_mismatch("ctrl_write_reg", word_t'(ctrl_write_reg),
                                             word_t'(head_reg));
                    assert (data_write_reg == head_val)
                        else report_mismatch("data_write_reg", data_write_reg, head_val);
                end
            end
            if (wren) begin
                stores_seen++;
                assert (st_addr_q.size() != 0) else begin
                    errors++;
                    $display("time %0t: unexpected store to %h", $time, address_dmem);
                end
                if (st_addr_q.size() != 0) begin
                    head_addr = st_addr_q.pop_front();
                    head_data = st_data_q.pop_front();
                    assert (address_dmem == head_addr)
                        else report_mismatch("address_dmem", address_dmem, head_addr);
                    assert (data == head_data)
                        else report_mismatch("data", data, head_data);
                end
            end
        end
    end

    // about four cycles per executed instruction covers stalls and flushes
    initial begin
        wait (model_ready);
        repeat (4 * model_steps + 20 + 2) @(posedge clock);
        $display("timeout: %0d register writes and %0d stores never arrived",
                 exp_reg_q.size(), st_addr_q.size());
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clock       = 1'b0;
        arst_n      = 1'b0;
        errors      = 0;
        writes_seen = 0;
        stores_seen = 0;
        model_ready = 1'b0;
        lfsr_state  = 32'h6722b1fd;
        build_program();
        run_model();
        model_ready = 1'b1;
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;
        // first cycle out of reset
        @(negedge clock);
        assert (!wren) else report_mismatch("wren", word_t'(wren), '0);
        assert (address_imem == '0) else report_mismatch("address_imem", address_imem, '0);
        assert (!ctrl_write_enable)
            else report_mismatch("ctrl_write_enable", word_t'(ctrl_write_enable), '0);
        while (exp_reg_q.size() != 0 || st_addr_q.size() != 0)
            @(posedge clock);
        // idle in the halt loop to catch stray writes
        repeat (12) @(posedge clock);
        assert (writes_seen == writes_expected)
            else report_mismatch("register write count", writes_seen, writes_expected);
        assert (stores_seen == stores_expected)
            else report_mismatch("store count", stores_seen, stores_expected);
        $display("errors %0d, register writes %0d of %0d, stores %0d of %0d",
                 errors, writes_seen, writes_expected, stores_seen, stores_expected);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
